// File: rename_subsys.f
+incdir+verification
src/isa_pkg.sv
src/rename_pkg.sv
src/inst_decoder.sv
src/rename_map_table.sv
src/preg_allocator.sv
src/rename_stage.sv
src/rename_top.sv
verification/rename_tb.sv

// File: verification/rename_tb_tasks.svh
`ifndef RENAME_TB_TASKS_SVH
`define RENAME_TB_TASKS_SVH

// Galois LFSR, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r    = {r[30:0], lfsr[0]};
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return r;
endfunction

function automatic areg_id_t rand_areg();
    areg_id_t r;
    r = areg_id_t'(rand_bits(5));
    return (r == '0) ? areg_id_t'(1) : r;  // Never x0
endfunction

function automatic pc_t rand_pc();
    logic [31:0] r;
    r = rand_bits(30);
    return {r[29:0], 2'b00};
endfunction

function automatic inst_word_u make_r(input opcode_t opc, input areg_id_t rd,
                                      input areg_id_t rs1, input areg_id_t rs2);
    inst_word_u w;
    w              = '0;
    w.rtype.opcode = opc;
    w.rtype.rd     = rd;
    w.rtype.rs1    = rs1;
    w.rtype.rs2    = rs2;
    return w;
endfunction

function automatic inst_word_u make_i(input opcode_t opc, input areg_id_t rd,
                                      input areg_id_t rs1, input logic [11:0] imm);
    inst_word_u w;
    w              = '0;
    w.itype.opcode = opc;
    w.itype.rd     = rd;
    w.itype.rs1    = rs1;
    w.itype.imm12  = imm;
    return w;
endfunction

task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = err_count;
    test_count++;
endtask

task automatic end_test();
    if (err_count == test_errs) begin
        $display("%s: passed", cur_test);
    end else begin
        $display("%s: failed with %0d errors", cur_test, err_count - test_errs);
    end
endtask

task automatic check_preg(input string field, input logic [PREG_W-1:0] exp,
                          input logic [PREG_W-1:0] act);
    if (act !== exp) begin
        $display("** Error: %s %s, expected %0d, actual %0d", cur_test, field, exp, act);
        err_count++;
    end
endtask

task automatic check_flag(input string field, input logic exp, input logic act);
    if (act !== exp) begin
        $display("** Error: %s %s, expected %b, actual %b", cur_test, field, exp, act);
        err_count++;
    end
endtask

task automatic check_pc(input string field, input pc_t exp, input pc_t act);
    if (act !== exp) begin
        $display("** Error: %s %s, expected %h, actual %h", cur_test, field, exp, act);
        err_count++;
    end
endtask

task automatic check_seq(input string field, input seq_id_t exp, input seq_id_t act);
    if (act !== exp) begin
        $display("** Error: %s %s, expected %0d, actual %0d", cur_test, field, exp, act);
        err_count++;
    end
endtask

task automatic check_count(input string field, input int exp, input int act);
    if (act != exp) begin
        $display("** Error: %s %s, expected %0d, actual %0d", cur_test, field, exp, act);
        err_count++;
    end
endtask

task automatic model_reset();
    for (int i = 0; i < ARF_SIZE; i++) begin
        map_model_valid[i] = 1'b0;
    end
    head_model  = '0;
    count_model = 0;
endtask

task automatic model_alloc(input areg_id_t rd);
    map_model[rd]       = head_model;
    map_model_valid[rd] = 1'b1;
    flight_areg.push_back(rd);
    flight_preg.push_back(head_model);
    head_model = head_model + 1'b1;   // Wraps at PRF_SIZE
    count_model++;
endtask

// Register usage by opcode, x0 never counts
task automatic expect_usage(input inst_word_u w, output logic u1, output logic u2,
                            output logic ud, output logic ill);
    opcode_t opc;
    opc = w.rtype.opcode;
    u1  = opc inside {OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_STORE, OPC_BRANCH};
    u2  = opc inside {OPC_OP, OPC_STORE, OPC_BRANCH};
    ud  = opc inside {OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_LUI};
    ill = !(u1 || ud);
    u1  = u1 && (w.rtype.rs1 != '0);
    u2  = u2 && (w.rtype.rs2 != '0);
    ud  = ud && (w.rtype.rd != '0);
endtask

// Hold the instruction until the DUT takes it
task automatic issue(input inst_word_u w, input pc_t pc, input seq_id_t seq);
    logic taken;
    in_valid_i = 1'b1;
    in_inst_i  = w;
    in_pc_i    = pc;
    in_seq_i   = seq;
    do begin
        @(negedge clk);
        taken = in_ready_o;     // Ready as seen by the coming edge
        @(posedge clk);
    end while (!taken);
    #1;
    in_valid_i = 1'b0;
endtask

task automatic rename_check(input inst_word_u w, input pc_t pc, input seq_id_t seq);
    logic              u1, u2, ud, ill;
    logic              exp_r1, exp_r2;
    logic [PREG_W-1:0] exp_prs1, exp_prs2, exp_prd;
    expect_usage(w, u1, u2, ud, ill);
    exp_r1   = u1 && map_model_valid[w.rtype.rs1];
    exp_r2   = u2 && map_model_valid[w.rtype.rs2];
    exp_prs1 = map_model[w.rtype.rs1];
    exp_prs2 = map_model[w.rtype.rs2];
    exp_prd  = head_model;
    issue(w, pc, seq);
    if (ud) begin
        model_alloc(w.rtype.rd);
    end
    check_flag("out_valid", 1'b1, out_valid_o);
    check_pc("pc", pc, out_pc_o);
    check_seq("seq", seq, out_seq_o);
    check_flag("prs1_renamed", exp_r1, out_prs1_renamed_o);
    check_flag("prs2_renamed", exp_r2, out_prs2_renamed_o);
    if (exp_r1) begin
        check_preg("prs1", exp_prs1, out_prs1_o);
    end
    if (exp_r2) begin
        check_preg("prs2", exp_prs2, out_prs2_o);
    end
    check_flag("has_rd", ud, out_has_rd_o);
    if (ud) begin
        check_preg("prd", exp_prd, out_prd_o);
    end
    check_flag("illegal", ill, out_illegal_o);
endtask

task automatic rename_next(input inst_word_u w);
    seq_tag = seq_tag + 1'b1;
    rename_check(w, rand_pc(), seq_tag);
endtask

// Retire pulse for the oldest in-flight id
task automatic retire_oldest();
    areg_id_t          a;
    logic [PREG_W-1:0] p;
    a = flight_areg.pop_front();
    p = flight_preg.pop_front();
    retire_valid_i  = 1'b1;
    retire_has_rd_i = 1'b1;
    retire_areg_i   = a;
    retire_preg_i   = p;
    @(negedge clk);
    ready_at_retire = in_ready_o;   // Ready during the free cycle
    @(posedge clk);
    #1;
    retire_valid_i  = 1'b0;
    retire_has_rd_i = 1'b0;
    if (map_model_valid[a] && (map_model[a] == p)) begin
        map_model_valid[a] = 1'b0;  // Only if still the owner
    end
    count_model--;
endtask

task automatic test_alloc_order();
    areg_id_t            dst [6];
    logic [ARF_SIZE-1:0] written;
    areg_id_t            spare;
    begin_test("alloc_order");
    written = '0;
    for (int i = 0; i < 6; i++) begin
        do begin
            dst[i] = rand_areg();
        end while (written[dst[i]]);
        written[dst[i]] = 1'b1;
        rename_next(make_r(OPC_OP, dst[i], rand_areg(), rand_areg()));
        check_preg("prd order", PREG_W'(i), out_prd_o);
    end
    do begin
        spare = rand_areg();
    end while (written[spare]);
    for (int i = 0; i < 6; i++) begin
        rename_next(make_r(OPC_OP, 5'd0, dst[i], spare));
        check_preg("reader prs1", PREG_W'(i), out_prs1_o);
        check_flag("unwritten source", 1'b0, out_prs2_renamed_o);
    end
    end_test();
endtask

task automatic test_opcode_forms();
    areg_id_t          a;
    logic [PREG_W-1:0] head_before;
    begin_test("opcode_forms");
    a = rand_areg();
    rename_next(make_r(OPC_OP, a, 5'd0, 5'd0));
    check_flag("x0 source", 1'b0, out_prs1_renamed_o);
    head_before = head_model;
    rename_next(make_r(OPC_OP, 5'd0, a, a));
    rename_next(make_r(OPC_STORE, rand_areg(), a, a));  // rd bits are immediate here
    rename_next(make_r(OPC_BRANCH, rand_areg(), a, a));
    rename_next(make_r(7'b1111111, rand_areg(), a, a));
    check_flag("unknown opcode", 1'b1, out_illegal_o);
    // Low immediate bits name a mapped register
    rename_next(make_i(OPC_OP_IMM, rand_areg(), a, {7'd0, a}));
    check_preg("prd after no-dest forms", head_before, out_prd_o);
    check_flag("op_imm rs2", 1'b0, out_prs2_renamed_o);
    rename_next(make_i(OPC_LUI, rand_areg(), a, 12'h5a5));
    check_flag("lui rs1", 1'b0, out_prs1_renamed_o);
    end_test();
endtask

task automatic test_exhaust_and_free();
    inst_word_u        stalled;
    pc_t               pc;
    logic [PREG_W-1:0] freed;
    begin_test("exhaust_and_free");
    while (count_model < PRF_SIZE) begin
        rename_next(make_r(OPC_OP, rand_areg(), rand_areg(), rand_areg()));
    end
    rename_next(make_r(OPC_STORE, rand_areg(), rand_areg(), rand_areg()));
    stalled = make_r(OPC_OP, rand_areg(), rand_areg(), 5'd0);
    pc      = rand_pc();
    seq_tag = seq_tag + 1'b1;
    in_valid_i = 1'b1;
    in_inst_i  = stalled;
    in_pc_i    = pc;
    in_seq_i   = seq_tag;
    repeat (3) begin
        @(posedge clk);
        #1;
        check_flag("ready while full", 1'b0, in_ready_o);
    end
    freed = flight_preg[0];
    retire_oldest();
    check_flag("ready in free cycle", 1'b0, ready_at_retire);
    rename_check(stalled, pc, seq_tag);
    check_preg("prd after free", freed, out_prd_o);
    end_test();
endtask

task automatic test_owner_clear();
    logic [PREG_W-1:0] first_id;
    begin_test("owner_clear");
    while (flight_preg.size() > 0) begin
        retire_oldest();
    end
    first_id = head_model;
    rename_next(make_r(OPC_OP, 5'd5, 5'd0, 5'd0));
    rename_next(make_r(OPC_OP, 5'd5, 5'd0, 5'd0));
    retire_oldest();
    rename_next(make_r(OPC_OP, 5'd0, 5'd5, 5'd0));
    check_flag("x5 after first retire", 1'b1, out_prs1_renamed_o);
    check_preg("x5 second id", first_id + 1'b1, out_prs1_o);
    retire_oldest();
    rename_next(make_r(OPC_OP, 5'd0, 5'd5, 5'd0));
    check_flag("x5 after second retire", 1'b0, out_prs1_renamed_o);
    end_test();
endtask

task automatic test_backpressure();
    inst_word_u        w_b;
    pc_t               pc_a, pc_b;
    seq_id_t           seq_a;
    logic [PREG_W-1:0] prd_a;
    int                xfers_before;
    begin_test("backpressure");
    @(posedge clk);     // Last result leaves the output register
    #1;
    xfers_before = out_xfers;
    out_ready_i  = 1'b0;
    pc_a    = rand_pc();
    seq_tag = seq_tag + 1'b1;
    seq_a   = seq_tag;
    prd_a   = head_model;
    rename_check(make_r(OPC_OP, rand_areg(), 5'd0, 5'd0), pc_a, seq_a);
    w_b     = make_r(OPC_OP, rand_areg(), rand_areg(), 5'd0);
    pc_b    = rand_pc();
    seq_tag = seq_tag + 1'b1;
    in_valid_i = 1'b1;
    in_inst_i  = w_b;
    in_pc_i    = pc_b;
    in_seq_i   = seq_tag;
    repeat (4) begin
        @(posedge clk);
        #1;
        check_flag("ready under backpressure", 1'b0, in_ready_o);
        check_flag("valid held", 1'b1, out_valid_o);
        check_pc("pc held", pc_a, out_pc_o);
        check_seq("seq held", seq_a, out_seq_o);
        check_preg("prd held", prd_a, out_prd_o);
    end
    out_ready_i = 1'b1;
    rename_check(w_b, pc_b, seq_tag);
    check_preg("no id consumed", prd_a + 1'b1, out_prd_o);
    rename_next(make_r(OPC_OP, rand_areg(), rand_areg(), rand_areg()));
    @(posedge clk);
    #1;
    check_count("output transfers", 3, out_xfers - xfers_before);
    end_test();
endtask

`endif

// File: verification/rename_tb.sv
`timescale 1ns/1ns

module rename_tb import isa_pkg::*, rename_pkg::*; ();

    localparam int PRF_SIZE = 16;
    localparam int PREG_W   = $clog2(PRF_SIZE);
    // Instructions and retires per test, fill and drain scale with PRF_SIZE
    localparam int N_INSTS     = 12 + 7 + (PRF_SIZE + 8) + (PRF_SIZE + 8) + 10;
    localparam int CYCLE_LIMIT = 16 + 3 * N_INSTS + 50;

    logic              clk;
    logic              rstn;
    logic              in_valid_i;
    logic              in_ready_o;
    inst_word_u        in_inst_i;
    pc_t               in_pc_i;
    seq_id_t           in_seq_i;
    logic              out_valid_o;
    logic              out_ready_i;
    pc_t               out_pc_o;
    seq_id_t           out_seq_o;
    logic [PREG_W-1:0] out_prs1_o;
    logic              out_prs1_renamed_o;
    logic [PREG_W-1:0] out_prs2_o;
    logic              out_prs2_renamed_o;
    logic [PREG_W-1:0] out_prd_o;
    logic              out_has_rd_o;
    logic              out_illegal_o;
    logic              retire_valid_i;
    logic              retire_has_rd_i;
    areg_id_t          retire_areg_i;
    logic [PREG_W-1:0] retire_preg_i;

    logic [31:0]       lfsr;
    int                err_count;
    int                test_errs;       // Errors before the current test
    int                test_count;
    int                cycle_count;
    int                out_xfers;       // Output handshakes seen
    string             cur_test;

    // Reference model of map and allocator
    logic [PREG_W-1:0] map_model [ARF_SIZE];
    logic              map_model_valid [ARF_SIZE];
    logic [PREG_W-1:0] head_model;
    int                count_model;
    areg_id_t          flight_areg [$];  // Oldest first
    logic [PREG_W-1:0] flight_preg [$];
    seq_id_t           seq_tag;
    logic              ready_at_retire;

    rename_top #(.PRF_SIZE(PRF_SIZE)) rename_top_i (.*);

    `include "rename_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (out_valid_o && out_ready_i) begin
            out_xfers <= out_xfers + 1;
        end
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the DUT stopped taking instructions",
                     cycle_count);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        lfsr            = 32'h58b7cb06;
        err_count       = 0;
        test_errs       = 0;
        test_count      = 0;
        cycle_count     = 0;
        out_xfers       = 0;
        seq_tag         = '0;
        rstn            = 1'b0;
        in_valid_i      = 1'b0;
        in_inst_i       = '0;
        in_pc_i         = '0;
        in_seq_i        = '0;
        out_ready_i     = 1'b1;
        retire_valid_i  = 1'b0;
        retire_has_rd_i = 1'b0;
        retire_areg_i   = '0;
        retire_preg_i   = '0;
        model_reset();
        repeat (16) @(posedge clk);
        #1;
        rstn = 1'b1;
        test_alloc_order();
        test_opcode_forms();
        test_exhaust_and_free();
        test_owner_clear();
        test_backpressure();
        $display("%0d tests run, %0d errors", test_count, err_count);
        if (err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: src/rename_top.sv
`timescale 1ns/1ns

module rename_top import isa_pkg::*, rename_pkg::*; #(
    parameter  int PRF_SIZE = 16,
    localparam int PREG_W   = $clog2(PRF_SIZE)
) (
    input  logic              clk,
    input  logic              rstn,
    // Instruction in
    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  inst_word_u        in_inst_i,
    input  pc_t               in_pc_i,
    input  seq_id_t           in_seq_i,
    // Renamed instruction out
    output logic              out_valid_o,
    input  logic              out_ready_i,
    output pc_t               out_pc_o,
    output seq_id_t           out_seq_o,
    output logic [PREG_W-1:0] out_prs1_o,
    output logic              out_prs1_renamed_o,
    output logic [PREG_W-1:0] out_prs2_o,
    output logic              out_prs2_renamed_o,
    output logic [PREG_W-1:0] out_prd_o,
    output logic              out_has_rd_o,
    output logic              out_illegal_o,
    // Retire
    input  logic              retire_valid_i,
    input  logic              retire_has_rd_i,
    input  areg_id_t          retire_areg_i,
    input  logic [PREG_W-1:0] retire_preg_i
);

    areg_id_t          dec_rs1, dec_rs2, dec_rd;
    logic              dec_rs1_used, dec_rs2_used, dec_rd_used, dec_illegal;
    areg_id_t          map_rd_id0, map_rd_id1;
    logic [PREG_W-1:0] map_rd_preg0, map_rd_preg1;
    logic              map_rd_valid0, map_rd_valid1;
    logic              map_wr_en;
    areg_id_t          map_wr_areg;
    logic [PREG_W-1:0] map_wr_preg;
    logic              can_alloc, alloc;
    logic [PREG_W-1:0] alloc_preg;
    wire               retire_free = retire_valid_i && retire_has_rd_i;

    inst_decoder inst_decoder_i (
        .inst_i(in_inst_i), .rs1_o(dec_rs1), .rs2_o(dec_rs2), .rd_o(dec_rd),
        .rs1_used_o(dec_rs1_used), .rs2_used_o(dec_rs2_used),
        .rd_used_o(dec_rd_used), .illegal_o(dec_illegal)
    );

    rename_stage #(.PRF_SIZE(PRF_SIZE)) rename_stage_i (.*,
        .dec_rs1_i(dec_rs1), .dec_rs2_i(dec_rs2), .dec_rd_i(dec_rd),
        .dec_rs1_used_i(dec_rs1_used), .dec_rs2_used_i(dec_rs2_used),
        .dec_rd_used_i(dec_rd_used), .dec_illegal_i(dec_illegal),
        .map_rd_id0_o(map_rd_id0), .map_rd_id1_o(map_rd_id1),
        .map_rd_preg0_i(map_rd_preg0), .map_rd_preg1_i(map_rd_preg1),
        .map_rd_valid0_i(map_rd_valid0), .map_rd_valid1_i(map_rd_valid1),
        .map_wr_en_o(map_wr_en), .map_wr_areg_o(map_wr_areg), .map_wr_preg_o(map_wr_preg),
        .can_alloc_i(can_alloc), .alloc_preg_i(alloc_preg), .alloc_o(alloc)
    );

    rename_map_table #(.PRF_SIZE(PRF_SIZE)) rename_map_table_i (
        .clk(clk), .rstn(rstn),
        .rd_id0_i(map_rd_id0), .rd_id1_i(map_rd_id1),
        .rd_preg0_o(map_rd_preg0), .rd_preg1_o(map_rd_preg1),
        .rd_valid0_o(map_rd_valid0), .rd_valid1_o(map_rd_valid1),
        .wr_en_i(map_wr_en), .wr_areg_i(map_wr_areg), .wr_preg_i(map_wr_preg),
        .clr_en_i(retire_free), .clr_areg_i(retire_areg_i), .clr_preg_i(retire_preg_i)
    );

    preg_allocator #(.PRF_SIZE(PRF_SIZE)) preg_allocator_i (
        .clk(clk), .rstn(rstn),
        .alloc_i(alloc), .can_alloc_o(can_alloc), .alloc_preg_o(alloc_preg),
        .free_i(retire_free), .free_preg_i(retire_preg_i)
    );

endmodule

// File: src/rename_stage.sv
`timescale 1ns/1ns

module rename_stage import isa_pkg::*, rename_pkg::*; #(
    parameter  int PRF_SIZE = 16,
    localparam int PREG_W   = $clog2(PRF_SIZE)
) (
    input  logic              clk,
    input  logic              rstn,
    // Input handshake
    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  pc_t               in_pc_i,
    input  seq_id_t           in_seq_i,
    // Output register
    output logic              out_valid_o,
    input  logic              out_ready_i,
    output pc_t               out_pc_o,
    output seq_id_t           out_seq_o,
    output logic [PREG_W-1:0] out_prs1_o,
    output logic              out_prs1_renamed_o,
    output logic [PREG_W-1:0] out_prs2_o,
    output logic              out_prs2_renamed_o,
    output logic [PREG_W-1:0] out_prd_o,
    output logic              out_has_rd_o,
    output logic              out_illegal_o,
    // Decoder fields
    input  areg_id_t          dec_rs1_i,
    input  areg_id_t          dec_rs2_i,
    input  areg_id_t          dec_rd_i,
    input  logic              dec_rs1_used_i,
    input  logic              dec_rs2_used_i,
    input  logic              dec_rd_used_i,
    input  logic              dec_illegal_i,
    // Map table
    output areg_id_t          map_rd_id0_o,
    output areg_id_t          map_rd_id1_o,
    input  logic [PREG_W-1:0] map_rd_preg0_i,
    input  logic [PREG_W-1:0] map_rd_preg1_i,
    input  logic              map_rd_valid0_i,
    input  logic              map_rd_valid1_i,
    output logic              map_wr_en_o,
    output areg_id_t          map_wr_areg_o,
    output logic [PREG_W-1:0] map_wr_preg_o,
    // Allocator
    input  logic              can_alloc_i,
    input  logic [PREG_W-1:0] alloc_preg_i,
    output logic              alloc_o
);

    logic stall;
    logic accept;
    logic rs1_renamed;
    logic rs2_renamed;

    // Needs a destination but no free id
    assign stall      = in_valid_i && dec_rd_used_i && !can_alloc_i;
    assign in_ready_o = (!out_valid_o || out_ready_i) && !stall;
    assign accept     = in_valid_i && in_ready_o;

    assign map_rd_id0_o = dec_rs1_i;
    assign map_rd_id1_o = dec_rs2_i;
    assign rs1_renamed  = dec_rs1_used_i && map_rd_valid0_i;
    assign rs2_renamed  = dec_rs2_used_i && map_rd_valid1_i;

    // Allocate and map in the accept cycle
    assign alloc_o       = accept && dec_rd_used_i;
    assign map_wr_en_o   = alloc_o;
    assign map_wr_areg_o = dec_rd_i;
    assign map_wr_preg_o = alloc_preg_i;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            out_valid_o <= 1'b0;
        end else if (accept) begin
            out_valid_o <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;    // Taken, nothing new behind it
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            out_pc_o           <= in_pc_i;
            out_seq_o          <= in_seq_i;
            out_prs1_o         <= rs1_renamed ? map_rd_preg0_i : '0;
            out_prs1_renamed_o <= rs1_renamed;
            out_prs2_o         <= rs2_renamed ? map_rd_preg1_i : '0;
            out_prs2_renamed_o <= rs2_renamed;
            out_prd_o          <= alloc_preg_i;
            out_has_rd_o       <= dec_rd_used_i;
            out_illegal_o      <= dec_illegal_i;
        end
    end

    a_out_hold: assert property (
        @(posedge clk) disable iff (!rstn)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable({out_pc_o, out_seq_o,
            out_prs1_o, out_prs1_renamed_o, out_prs2_o, out_prs2_renamed_o,
            out_prd_o, out_has_rd_o, out_illegal_o})
    ) else $error("rename output changed while stalled");

endmodule

// File: src/preg_allocator.sv
`timescale 1ns/1ns

module preg_allocator #(
    parameter  int PRF_SIZE = 16,
    localparam int PREG_W   = $clog2(PRF_SIZE)
) (
    input  logic              clk,
    input  logic              rstn,
    // Allocation side
    input  logic              alloc_i,
    output logic              can_alloc_o,
    output logic [PREG_W-1:0] alloc_preg_o,
    // Free side, from retire
    input  logic              free_i,
    input  logic [PREG_W-1:0] free_preg_i
);

    logic [PREG_W-1:0] head_q;      // Next id to hand out
    logic [PREG_W:0]   count_q;     // Ids in flight, 0 to PRF_SIZE
    logic [PREG_W-1:0] oldest;
    logic              alloc_fire;

    // Top bit set only when every id is in flight
    assign can_alloc_o  = !count_q[PREG_W];
    assign alloc_preg_o = head_q;
    assign alloc_fire   = alloc_i && can_alloc_o;

    // Wraps modulo PRF_SIZE, full case gives head itself
    assign oldest = head_q - count_q[PREG_W-1:0];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            head_q  <= '0;
            count_q <= '0;
        end else begin
            if (alloc_fire) begin
                head_q <= head_q + 1'b1;
            end
            case ({alloc_fire, free_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // Both or neither
            endcase
        end
    end

    // Circular handout needs retire in allocation order
    a_free_in_order: assert property (
        @(posedge clk) disable iff (!rstn) free_i |-> (free_preg_i == oldest)
    ) else $error("free of %0d, oldest in flight is %0d", free_preg_i, oldest);

    a_free_not_empty: assert property (
        @(posedge clk) disable iff (!rstn) free_i |-> (count_q != '0)
    ) else $error("free with no id in flight");

    a_no_alloc_full: assert property (
        @(posedge clk) disable iff (!rstn) alloc_i |-> can_alloc_o
    ) else $error("alloc requested while allocator is full");

endmodule

// File: src/rename_map_table.sv
`timescale 1ns/1ns

module rename_map_table import isa_pkg::*, rename_pkg::*; #(
    parameter  int PRF_SIZE = 16,
    localparam int PREG_W   = $clog2(PRF_SIZE)
) (
    input  logic              clk,
    input  logic              rstn,
    // Read ports
    input  areg_id_t          rd_id0_i,
    input  areg_id_t          rd_id1_i,
    output logic [PREG_W-1:0] rd_preg0_o,
    output logic [PREG_W-1:0] rd_preg1_o,
    output logic              rd_valid0_o,
    output logic              rd_valid1_o,
    // Write port from rename
    input  logic              wr_en_i,
    input  areg_id_t          wr_areg_i,
    input  logic [PREG_W-1:0] wr_preg_i,
    // Clear port from retire
    input  logic              clr_en_i,
    input  areg_id_t          clr_areg_i,
    input  logic [PREG_W-1:0] clr_preg_i
);

    logic [PREG_W-1:0]   map_q [ARF_SIZE];
    logic [ARF_SIZE-1:0] valid_q;    // Entry points to a physical reg
    logic                clr_owned;

    assign rd_preg0_o  = map_q[rd_id0_i];
    assign rd_preg1_o  = map_q[rd_id1_i];
    assign rd_valid0_o = valid_q[rd_id0_i];
    assign rd_valid1_o = valid_q[rd_id1_i];

    // Retiring reg still owns the entry
    assign clr_owned = valid_q[clr_areg_i] && (map_q[clr_areg_i] == clr_preg_i);

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            map_q[wr_areg_i] <= wr_preg_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
        end else begin
            if (clr_en_i && clr_owned) begin
                valid_q[clr_areg_i] <= 1'b0;
            end
            // Later assignment, so a write to the same areg wins
            if (wr_en_i) begin
                valid_q[wr_areg_i] <= 1'b1;
            end
        end
    end

    // Retire of x0 would mean a bogus has_rd upstream
    a_clr_not_x0: assert property (
        @(posedge clk) disable iff (!rstn) clr_en_i |-> (clr_areg_i != '0)
    ) else $error("map clear targets x0");

endmodule

// File: src/inst_decoder.sv
`timescale 1ns/1ns

module inst_decoder import isa_pkg::*; (
    input  inst_word_u inst_i,
    output areg_id_t   rs1_o,
    output areg_id_t   rs2_o,
    output areg_id_t   rd_o,
    output logic       rs1_used_o,
    output logic       rs2_used_o,
    output logic       rd_used_o,
    output logic       illegal_o
);

    opcode_t opcode;
    logic    shamt_ok;  // Upper imm bits legal for a shift
    logic    use_rs1;
    logic    use_rs2;
    logic    use_rd;

    // Register fields sit at the same bits in every format
    assign opcode = inst_i.itype.opcode;
    assign rs1_o  = inst_i.itype.rs1;
    assign rs2_o  = inst_i.rtype.rs2;
    assign rd_o   = inst_i.itype.rd;

    always_comb begin
        case (inst_i.itype.funct3)
            F3_SLLI:      shamt_ok = (inst_i.itype.imm12[11:5] == F7_BASE);
            F3_SRLI_SRAI: shamt_ok = (inst_i.itype.imm12[11:5] == F7_BASE) ||
                                     (inst_i.itype.imm12[11:5] == F7_ALT);
            default:      shamt_ok = 1'b1;  // Plain immediate ALU ops
        endcase
    end

    always_comb begin
        use_rs1   = 1'b0;
        use_rs2   = 1'b0;
        use_rd    = 1'b0;
        illegal_o = 1'b0;
        case (opcode)
            OPC_OP: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                use_rd  = 1'b1;
            end
            OPC_OP_IMM: begin
                use_rs1   = shamt_ok;
                use_rd    = shamt_ok;
                illegal_o = !shamt_ok;
            end
            OPC_LOAD: begin
                use_rs1 = 1'b1;
                use_rd  = 1'b1;
            end
            OPC_STORE, OPC_BRANCH: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            OPC_LUI:  use_rd = 1'b1;
            default:  illegal_o = 1'b1;
        endcase
    end

    // x0 is never renamed
    assign rs1_used_o = use_rs1 && (rs1_o != '0);
    assign rs2_used_o = use_rs2 && (rs2_o != '0);
    assign rd_used_o  = use_rd && (rd_o != '0);

endmodule

// File: src/rename_pkg.sv
package rename_pkg;

    // Architectural register file depth
    localparam int ARF_SIZE = 32;

    // Program counter of the renamed instruction
    typedef logic [31:0] pc_t;

    // Sequence tag, passed through untouched
    typedef logic [5:0] seq_id_t;

endpackage

// File: src/isa_pkg.sv
package isa_pkg;

    // Architectural register index, x0 to x31
    typedef logic [4:0] areg_id_t;

    typedef logic [6:0] opcode_t;

    // Major opcodes handled by rename
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LUI    = 7'b0110111;

    // Shift-immediate encodings inside OP_IMM
    localparam logic [2:0] F3_SLLI      = 3'b001;
    localparam logic [2:0] F3_SRLI_SRAI = 3'b101;
    localparam logic [6:0] F7_BASE      = 7'b0000000;
    localparam logic [6:0] F7_ALT       = 7'b0100000; // SRAI and SUB style

    // R-type layout
    typedef struct packed {
        logic [6:0] funct7;
        areg_id_t   rs2;
        areg_id_t   rs1;
        logic [2:0] funct3;
        areg_id_t   rd;
        opcode_t    opcode;
    } inst_rtype_t;

    // I-type layout
    typedef struct packed {
        logic [11:0] imm12;
        areg_id_t    rs1;
        logic [2:0]  funct3;
        areg_id_t    rd;
        opcode_t     opcode;
    } inst_itype_t;

    // One instruction word, read as either format
    typedef union packed {
        inst_rtype_t rtype;
        inst_itype_t itype;
    } inst_word_u;

endpackage
